// File: csi2_tx_pkg.sv
// CSI-2 transmit packet builder, shared definitions
// data type codes, the pixel input and lane byte records, the packed
// RAW10 group and the packet header with its two views

package csi2_tx_pkg;

    // CSI-2 data type codes
    localparam logic [5:0] DT_FRAME_START = 6'h00;
    localparam logic [5:0] DT_FRAME_END   = 6'h01;
    localparam logic [5:0] DT_RAW10       = 6'h2B;

    // pixel stream from the sensor side
    typedef struct packed {
        logic       frame_valid;  // level, high for the whole frame
        logic       line_valid;   // level, high for the whole line
        logic       pixel_valid;  // strobe, one per pixel
        logic [9:0] data;
    } pixel_in_t;

    // four pixels packed the RAW10 way, byte 0 in bits 7:0
    typedef struct packed {
        logic [7:0]      lsbs;    // byte 4, pixel n low bits at 2n+1:2n
        logic [3:0][7:0] msbs;    // bytes 0 to 3, upper 8 bits of pixels 0 to 3
    } raw10_group_t;

    // packet header as seen by the sequencer
    typedef struct packed {
        logic [7:0]  ecc;             // upper 2 bits always zero
        logic [15:0] word_count;
        logic [1:0]  virtual_channel;
        logic [5:0]  data_type;
    } csi2_header_fields_t;

    // same 32 bits as the four bytes on the wire
    // byte 0 data id, 1 and 2 word count low/high, 3 ecc
    typedef union packed {
        csi2_header_fields_t fields;
        logic [3:0][7:0]     bytes;
    } csi2_header_u;

    // one byte lane towards the PHY
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       first;        // first byte of a packet
        logic       last;         // last byte of a packet
    } lane_byte_t;

endpackage

// File: raw10_packer.sv
// RAW10 pixel packer
// collects four 10-bit pixels into one five-byte RAW10 group, writes it
// out a cycle after the fourth pixel, and flags frame start, frame end
// and the end of every line

`timescale 1ns/100ps

module raw10_packer import csi2_tx_pkg::*; #(
    parameter int LINE_PIXELS = 16
) (
    input  logic         tx_byte_clock,
    input  logic         tx_byte_reset_n,
    input  pixel_in_t    pixel_i,
    output raw10_group_t group_o,
    output logic         group_write_o,
    output logic         frame_start_o,
    output logic         frame_end_o,
    output logic         line_done_o
);

    localparam int PIX_W = (LINE_PIXELS > 4) ? $clog2(LINE_PIXELS) : 2;

    logic             fv_q;        // delayed frame_valid for edge detect
    logic [PIX_W-1:0] pix_cnt_q;   // pixel index within the line
    logic             line_end_q;  // last group of the line is being written
    logic             pix_strobe;
    logic             line_last;
    logic [1:0]       slot;
    raw10_group_t     group_q;

    assign pix_strobe = pixel_i.pixel_valid & pixel_i.line_valid;
    assign slot       = pix_cnt_q[1:0];
    assign line_last  = pix_cnt_q == PIX_W'(LINE_PIXELS - 1);

    always_ff @(posedge tx_byte_clock or negedge tx_byte_reset_n) begin
        if (!tx_byte_reset_n) begin
            fv_q          <= 1'b0;
            pix_cnt_q     <= '0;
            line_end_q    <= 1'b0;
            group_write_o <= 1'b0;
            line_done_o   <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
        end else begin
            fv_q          <= pixel_i.frame_valid;
            frame_start_o <= pixel_i.frame_valid & ~fv_q;  // rising edge
            frame_end_o   <= ~pixel_i.frame_valid & fv_q;  // falling edge
            group_write_o <= pix_strobe && slot == 2'd3;
            line_end_q    <= pix_strobe && line_last;
            line_done_o   <= line_end_q;                   // one after the last write
            if (pix_strobe) begin
                pix_cnt_q <= line_last ? '0 : pix_cnt_q + 1'b1;
            end
        end
    end

    // each strobed pixel lands in its slot of the group
    always_ff @(posedge tx_byte_clock) begin
        if (pix_strobe) begin
            group_q.msbs[slot]             <= pixel_i.data[9:2];
            group_q.lsbs[{slot, 1'b0} +: 2] <= pixel_i.data[1:0];
        end
    end

    assign group_o = group_q;

endmodule

// File: csi2_line_fifo.sv
// line buffer FIFO
// circular buffer of RAW10 groups between the packer and the packet
// sequencer, with a registered read port valid the cycle after a read

`timescale 1ns/100ps

module csi2_line_fifo import csi2_tx_pkg::*; #(
    parameter int FIFO_GROUPS = 16
) (
    input  logic         tx_byte_clock,
    input  logic         tx_byte_reset_n,
    input  raw10_group_t group_i,
    input  logic         write_i,
    input  logic         read_i,
    output raw10_group_t group_o
);

    localparam int PTR_W = (FIFO_GROUPS > 1) ? $clog2(FIFO_GROUPS) : 1;

    raw10_group_t     mem_q [FIFO_GROUPS];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;

    // wraps at the buffer size, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_GROUPS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge tx_byte_clock or negedge tx_byte_reset_n) begin
        if (!tx_byte_reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (write_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (read_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
        end
    end

    always_ff @(posedge tx_byte_clock) begin
        if (write_i) begin
            mem_q[wr_ptr_q] <= group_i;
        end
        if (read_i) begin
            group_o <= mem_q[rd_ptr_q];  // holds until the next read
        end
    end

endmodule

// File: csi2_header_ecc.sv
// CSI-2 packet header ECC
// six Hamming parity bits over the 24 bits of data identifier and
// word count, as XOR trees with the fixed masks of the CSI-2 spec

`timescale 1ns/100ps

module csi2_header_ecc import csi2_tx_pkg::*; (
    input  csi2_header_fields_t header_fields_i,
    output logic [5:0]          ecc_o
);

    // parity masks, P0 in the lowest slot
    localparam logic [5:0][23:0] ECC_MASK = {
        24'hEFFC00,  // P5
        24'hDF03F0,  // P4
        24'hB8E38E,  // P3
        24'h749A6D,  // P2
        24'hF2555B,  // P1
        24'hF12CB7   // P0
    };

    logic [23:0] header_data;

    // D[7:0] data id, D[23:8] word count
    assign header_data = {
        header_fields_i.word_count,
        header_fields_i.virtual_channel,
        header_fields_i.data_type
    };

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            ecc_o[i] = ^(header_data & ECC_MASK[i]);
        end
    end

endmodule

// File: csi2_payload_crc.sv
// CSI-2 payload CRC-16
// reflected polynomial 0x8408, preset to all ones, one byte folded in
// per enabled cycle with the LSB first

`timescale 1ns/100ps

module csi2_payload_crc (
    input  logic        tx_byte_clock,
    input  logic        tx_byte_reset_n,
    input  logic        crc_clear_i,
    input  logic        crc_en_i,
    input  logic [7:0]  byte_i,
    output logic [15:0] crc_o
);

    localparam logic [15:0] CRC_POLY = 16'h8408;
    localparam logic [15:0] CRC_SEED = 16'hFFFF;

    logic [15:0] crc_q;
    logic [15:0] crc_next;

    // eight serial steps unrolled
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ byte_i[i]) begin
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge tx_byte_clock or negedge tx_byte_reset_n) begin
        if (!tx_byte_reset_n) begin
            crc_q <= CRC_SEED;
        end else if (crc_clear_i) begin
            crc_q <= CRC_SEED;    // start of a new payload
        end else if (crc_en_i) begin
            crc_q <= crc_next;
        end
    end

    assign crc_o = crc_q;  // sent low byte first

endmodule

// File: csi2_packet_ctrl.sv
// CSI-2 packet sequencer
// queues frame start, finished lines and frame end, then walks each
// packet through header, payload and CRC onto the byte lane; frame end
// waits for all lines of its frame and the next frame start waits for it

`timescale 1ns/100ps

module csi2_packet_ctrl import csi2_tx_pkg::*; #(
    parameter int LINE_PIXELS     = 16,
    parameter int VIRTUAL_CHANNEL = 0
) (
    input  logic                tx_byte_clock,
    input  logic                tx_byte_reset_n,
    input  logic                frame_start_i,
    input  logic                frame_end_i,
    input  logic                line_done_i,
    input  raw10_group_t        group_i,
    input  logic [5:0]          ecc_i,
    input  logic [15:0]         crc_i,
    output logic                read_o,
    output csi2_header_fields_t header_fields_o,
    output logic                crc_clear_o,
    output logic                crc_en_o,
    output logic [7:0]          crc_byte_o,
    output lane_byte_t          lane_o
);

    localparam logic [15:0] WORD_COUNT = 16'(LINE_PIXELS * 10 / 8);
    localparam int          GROUPS     = LINE_PIXELS / 4;
    localparam int          GROUP_W    = (GROUPS > 1) ? $clog2(GROUPS) : 1;

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_HEADER  = 3'd1;
    localparam logic [2:0] ST_PAYLOAD = 3'd2;
    localparam logic [2:0] ST_CRC     = 3'd3;
    localparam logic [2:0] ST_GAP     = 3'd4;

    logic [2:0]          state_q;
    logic [2:0]          byte_cnt_q;   // byte within header, group or crc
    logic [GROUP_W-1:0]  group_cnt_q;
    logic                pending_fs_q;
    logic                pending_fe_q;
    logic [3:0]          lines_q;      // lines buffered but not yet sent
    csi2_header_fields_t header_q;
    lane_byte_t          lane_q;
    csi2_header_u        header_word;
    logic                have_fs;
    logic                have_fe;
    logic                have_line;
    logic                take_fs;
    logic                take_fe;
    logic                take_line;
    logic                is_long;
    logic                last_group;
    logic [7:0]          payload_byte;

    // include this cycle's events so nothing is served out of order
    assign have_fs   = pending_fs_q | frame_start_i;
    assign have_fe   = pending_fe_q | frame_end_i;
    assign have_line = (lines_q != 4'd0) | line_done_i;

    always_comb begin
        take_fs   = 1'b0;
        take_fe   = 1'b0;
        take_line = 1'b0;
        if (state_q == ST_IDLE) begin
            if (have_fe) begin
                take_line = have_line;   // drain the old frame first
                take_fe   = ~have_line;
            end else if (have_fs) begin
                take_fs = 1'b1;
            end else begin
                take_line = have_line;
            end
        end
    end

    assign is_long      = header_q.data_type == DT_RAW10;
    assign last_group   = group_cnt_q == GROUP_W'(GROUPS - 1);
    assign payload_byte = (byte_cnt_q == 3'd4) ? group_i.lsbs : group_i.msbs[byte_cnt_q[1:0]];

    always_comb begin
        header_word.fields     = header_q;
        header_word.fields.ecc = {2'b00, ecc_i};
    end

    // read one cycle ahead of the first byte of each group
    assign read_o = (state_q == ST_HEADER && byte_cnt_q == 3'd3 && is_long) ||
                    (state_q == ST_PAYLOAD && byte_cnt_q == 3'd4 && !last_group);

    assign header_fields_o = header_q;
    assign crc_clear_o     = state_q == ST_HEADER;
    assign crc_en_o        = state_q == ST_PAYLOAD;
    assign crc_byte_o      = payload_byte;

    always_ff @(posedge tx_byte_clock or negedge tx_byte_reset_n) begin
        if (!tx_byte_reset_n) begin
            pending_fs_q <= 1'b0;
            pending_fe_q <= 1'b0;
            lines_q      <= 4'd0;
        end else begin
            pending_fs_q <= have_fs & ~take_fs;
            pending_fe_q <= have_fe & ~take_fe;
            lines_q      <= lines_q + {3'b000, line_done_i} - {3'b000, take_line};
        end
    end

    always_ff @(posedge tx_byte_clock or negedge tx_byte_reset_n) begin
        if (!tx_byte_reset_n) begin
            state_q     <= ST_IDLE;
            byte_cnt_q  <= 3'd0;
            group_cnt_q <= '0;
            header_q    <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    byte_cnt_q  <= 3'd0;
                    group_cnt_q <= '0;
                    if (take_fs | take_fe | take_line) begin
                        state_q                  <= ST_HEADER;
                        header_q.ecc             <= 8'h00;
                        header_q.virtual_channel <= 2'(VIRTUAL_CHANNEL);
                        header_q.word_count      <= take_line ? WORD_COUNT : 16'h0000;
                        header_q.data_type       <= take_line ? DT_RAW10 :
                                                    take_fe   ? DT_FRAME_END : DT_FRAME_START;
                    end
                end
                ST_HEADER: begin
                    byte_cnt_q <= byte_cnt_q + 3'd1;
                    if (byte_cnt_q == 3'd3) begin
                        byte_cnt_q <= 3'd0;
                        state_q    <= is_long ? ST_PAYLOAD : ST_GAP;
                    end
                end
                ST_PAYLOAD: begin
                    byte_cnt_q <= byte_cnt_q + 3'd1;
                    if (byte_cnt_q == 3'd4) begin
                        byte_cnt_q  <= 3'd0;
                        group_cnt_q <= group_cnt_q + 1'b1;
                        if (last_group) begin
                            state_q <= ST_CRC;
                        end
                    end
                end
                ST_CRC: begin
                    byte_cnt_q <= byte_cnt_q + 3'd1;
                    if (byte_cnt_q == 3'd1) begin
                        byte_cnt_q <= 3'd0;
                        state_q    <= ST_GAP;
                    end
                end
                default: state_q <= ST_IDLE;  // gap, then back to idle
            endcase
        end
    end

    always_ff @(posedge tx_byte_clock or negedge tx_byte_reset_n) begin
        if (!tx_byte_reset_n) begin
            lane_q <= '0;
        end else begin
            lane_q.valid <= state_q == ST_HEADER || state_q == ST_PAYLOAD || state_q == ST_CRC;
            lane_q.first <= state_q == ST_HEADER && byte_cnt_q == 3'd0;
            lane_q.last  <= (state_q == ST_HEADER && byte_cnt_q == 3'd3 && !is_long) ||
                            (state_q == ST_CRC && byte_cnt_q == 3'd1);
            case (state_q)
                ST_HEADER:  lane_q.data <= header_word.bytes[byte_cnt_q[1:0]];
                ST_PAYLOAD: lane_q.data <= payload_byte;
                ST_CRC:     lane_q.data <= byte_cnt_q[0] ? crc_i[15:8] : crc_i[7:0];
                default:    lane_q.data <= 8'h00;
            endcase
        end
    end

    assign lane_o = lane_q;

endmodule

// File: csi2_tx_top.sv
// CSI-2 transmit packet builder, top level
// RAW10 pixel stream in, packet byte lane out, one virtual channel,
// everything in the byte clock domain; sets the line geometry and
// buffer depth for the blocks below

`timescale 1ns/100ps

module csi2_tx_top import csi2_tx_pkg::*; #(
    parameter int LINE_PIXELS     = 16,   // multiple of 4
    parameter int VIRTUAL_CHANNEL = 0,
    parameter int FIFO_GROUPS     = 16    // at least two lines of groups
) (
    input  logic       tx_byte_clock,
    input  logic       tx_byte_reset_n,
    input  pixel_in_t  pixel_i,
    output lane_byte_t lane_o
);

    raw10_group_t        packed_group;
    raw10_group_t        fifo_group;
    logic                group_write;
    logic                frame_start;
    logic                frame_end;
    logic                line_done;
    logic                fifo_read;
    csi2_header_fields_t header_fields;
    logic [5:0]          header_ecc;
    logic                crc_clear;
    logic                crc_en;
    logic [7:0]          crc_byte;
    logic [15:0]         payload_crc;

    raw10_packer #(
        .LINE_PIXELS(LINE_PIXELS)
    ) u_packer (
        .tx_byte_clock  (tx_byte_clock),
        .tx_byte_reset_n(tx_byte_reset_n),
        .pixel_i        (pixel_i),
        .group_o        (packed_group),
        .group_write_o  (group_write),
        .frame_start_o  (frame_start),
        .frame_end_o    (frame_end),
        .line_done_o    (line_done)
    );

    csi2_line_fifo #(
        .FIFO_GROUPS(FIFO_GROUPS)
    ) u_fifo (
        .tx_byte_clock  (tx_byte_clock),
        .tx_byte_reset_n(tx_byte_reset_n),
        .group_i        (packed_group),
        .write_i        (group_write),
        .read_i         (fifo_read),
        .group_o        (fifo_group)
    );

    csi2_header_ecc u_ecc (
        .header_fields_i(header_fields),
        .ecc_o          (header_ecc)
    );

    csi2_payload_crc u_crc (
        .tx_byte_clock  (tx_byte_clock),
        .tx_byte_reset_n(tx_byte_reset_n),
        .crc_clear_i    (crc_clear),
        .crc_en_i       (crc_en),
        .byte_i         (crc_byte),
        .crc_o          (payload_crc)
    );

    csi2_packet_ctrl #(
        .LINE_PIXELS    (LINE_PIXELS),
        .VIRTUAL_CHANNEL(VIRTUAL_CHANNEL)
    ) u_ctrl (
        .tx_byte_clock  (tx_byte_clock),
        .tx_byte_reset_n(tx_byte_reset_n),
        .frame_start_i  (frame_start),
        .frame_end_i    (frame_end),
        .line_done_i    (line_done),
        .group_i        (fifo_group),
        .ecc_i          (header_ecc),
        .crc_i          (payload_crc),
        .read_o         (fifo_read),
        .header_fields_o(header_fields),
        .crc_clear_o    (crc_clear),
        .crc_en_o       (crc_en),
        .crc_byte_o     (crc_byte),
        .lane_o         (lane_o)
    );

endmodule

// File: csi2_tx_tb.sv
// testbench for the CSI-2 transmit packet builder
// drives random RAW10 frames from an xorshift source, builds the expected
// packet bytes with its own packing, ECC and CRC model, and checks every
// lane byte, every header and the packet framing

`timescale 1ns/100ps

module csi2_tx_tb import csi2_tx_pkg::*; ();

    localparam int          LINE_PIXELS = 16;
    localparam logic [1:0]  VC          = 2'd0;
    localparam int          DRAIN_LIMIT = 2000;   // cycles allowed for the lane to go quiet

    logic         tx_byte_clock;
    logic         tx_byte_reset_n;
    pixel_in_t    pixel;
    lane_byte_t   lane;
    logic [31:0]  rng_state;
    logic         in_packet;                      // monitor is between first and last

    lane_byte_t   exp_bytes [$];
    string        exp_tags [$];                   // test name of each expected byte
    csi2_header_u exp_headers [$];
    logic [9:0]   line_pix [$];                   // pixels of the line being driven

    csi2_tx_top #(
        .LINE_PIXELS(LINE_PIXELS)
    ) u_dut (
        .tx_byte_clock  (tx_byte_clock),
        .tx_byte_reset_n(tx_byte_reset_n),
        .pixel_i        (pixel),
        .lane_o         (lane)
    );

    initial begin
        tx_byte_clock = 1'b0;
        forever #2 tx_byte_clock = ~tx_byte_clock;
    end

    // one xorshift32 step per call
    function automatic int unsigned next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_below(input int unsigned n);
        return int'(next_rand() % n);
    endfunction

    // header parity equations with D0 as the LSB of the data identifier
    function automatic logic [5:0] spec_ecc(input logic [23:0] d);
        logic [5:0] p;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^
               d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^
               d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^
               d[18] ^ d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^
               d[19] ^ d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^
               d[19] ^ d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^
               d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
        return p;
    endfunction

    // one CRC-16 byte step over the reflected poly 0x8408 with the LSB first
    function automatic logic [15:0] crc_fold(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        logic [7:0]  d;
        logic        fb;
        c = crc;
        d = b;
        repeat (8) begin
            fb = c[0] ^ d[0];
            c  = c >> 1;
            d  = d >> 1;
            if (fb) begin
                c = c ^ 16'h8408;
            end
        end
        return c;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string test, input lane_byte_t exp, input lane_byte_t act);
        if (act !== exp) begin
            abort_run({$sformatf("[FAIL] %s: expected valid=%0b data=%02h first=%0b last=%0b",
                                 test, exp.valid, exp.data, exp.first, exp.last),
                       $sformatf(", actual valid=%0b data=%02h first=%0b last=%0b",
                                 act.valid, act.data, act.first, act.last)});
        end
    endtask

    task automatic check_header(input string test, input csi2_header_u exp,
                                input csi2_header_u act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected header %08h, actual header %08h",
                                test, exp, act));
        end
    endtask

    task automatic append_byte(input string tag, input logic [7:0] data,
                               input logic first, input logic last);
        lane_byte_t b;
        b.valid = 1'b1;
        b.data  = data;
        b.first = first;
        b.last  = last;
        exp_bytes.push_back(b);
        exp_tags.push_back(tag);
    endtask

    // wire order is data id, word count low, word count high, ecc
    task automatic expect_header(input string tag, input logic [5:0] dt,
                                 input logic [15:0] wc, input logic short_pkt);
        csi2_header_u h;
        h.fields.data_type       = dt;
        h.fields.virtual_channel = VC;
        h.fields.word_count      = wc;
        h.fields.ecc             = {2'b00, spec_ecc({wc, VC, dt})};
        exp_headers.push_back(h);
        append_byte(tag, {VC, dt}, 1'b1, 1'b0);
        append_byte(tag, wc[7:0], 1'b0, 1'b0);
        append_byte(tag, wc[15:8], 1'b0, 1'b0);
        append_byte(tag, h.fields.ecc, 1'b0, short_pkt);
    endtask

    task automatic expect_line_packet();
        logic [7:0]  pay [$];
        logic [15:0] crc;
        for (int g = 0; g < LINE_PIXELS; g += 4) begin
            for (int k = 0; k < 4; k++) begin
                pay.push_back(line_pix[g + k][9:2]);   // upper 8 bits first
            end
            pay.push_back({line_pix[g + 3][1:0], line_pix[g + 2][1:0],
                           line_pix[g + 1][1:0], line_pix[g][1:0]});
        end
        expect_header("line_header", DT_RAW10, 16'(pay.size()), 1'b0);  // payload byte count
        crc = 16'hFFFF;
        foreach (pay[i]) begin
            crc = crc_fold(crc, pay[i]);
            append_byte("payload", pay[i], 1'b0, 1'b0);
        end
        append_byte("crc", crc[7:0], 1'b0, 1'b0);    // low byte first
        append_byte("crc", crc[15:8], 1'b0, 1'b1);
    endtask

    task automatic drive_line();
        logic [9:0] value;
        logic       strobe;
        line_pix.delete();
        while (line_pix.size() < LINE_PIXELS) begin
            @(posedge tx_byte_clock);
            value  = 10'(next_rand());
            strobe = rand_below(3) != 0;               // about two pixels in three cycles
            pixel.line_valid  <= 1'b1;
            pixel.pixel_valid <= strobe;
            pixel.data        <= value;
            if (strobe) begin
                line_pix.push_back(value);
            end
        end
        @(posedge tx_byte_clock);
        pixel.line_valid  <= 1'b0;
        pixel.pixel_valid <= 1'b0;
        expect_line_packet();
        repeat (16 + LINE_PIXELS / 2 + rand_below(16)) @(posedge tx_byte_clock);  // blanking
    endtask

    task automatic drive_frame(input int lines);
        @(posedge tx_byte_clock);
        pixel.frame_valid <= 1'b1;
        expect_header("frame_start", DT_FRAME_START, 16'h0000, 1'b1);
        repeat (4 + rand_below(8)) @(posedge tx_byte_clock);
        for (int n = 0; n < lines; n++) begin
            drive_line();
        end
        @(posedge tx_byte_clock);
        pixel.frame_valid <= 1'b0;
        expect_header("frame_end", DT_FRAME_END, 16'h0000, 1'b1);
        repeat (30 + rand_below(20)) @(posedge tx_byte_clock);
    endtask

    // collects lane bytes at the falling edge, where they are stable
    initial begin : lane_monitor
        lane_byte_t   exp_b;
        lane_byte_t   hdr_lane [$];               // header bytes held until the ecc byte is in
        csi2_header_u hdr_act;
        string        tag;
        int           byte_idx;
        logic         after_last;
        in_packet  = 1'b0;
        after_last = 1'b0;
        byte_idx   = 0;
        hdr_act    = '0;
        forever begin
            @(negedge tx_byte_clock);
            if (tx_byte_reset_n && lane.valid) begin
                if (after_last) begin
                    abort_run("a packet started right after the previous one, no gap cycle");
                end
                if (!in_packet && !lane.first) begin
                    abort_run("valid byte on the lane outside any packet");
                end
                if (lane.first) begin
                    byte_idx = 0;
                    hdr_lane.delete();
                end
                if ((byte_idx < 4) ? exp_headers.size() == 0 : exp_bytes.size() == 0) begin
                    abort_run("valid byte on the lane while no packet was expected");
                end
                if (byte_idx < 4) begin
                    hdr_act.bytes = {lane.data, hdr_act.bytes[3:1]};
                    hdr_lane.push_back(lane);
                end
                if (byte_idx == 3) begin
                    check_header(exp_tags[0], exp_headers.pop_front(), hdr_act);
                    while (hdr_lane.size() != 0) begin
                        exp_b = exp_bytes.pop_front();
                        tag   = exp_tags.pop_front();
                        check_byte(tag, exp_b, hdr_lane.pop_front());
                    end
                end else if (byte_idx > 3) begin
                    exp_b = exp_bytes.pop_front();
                    tag   = exp_tags.pop_front();
                    check_byte(tag, exp_b, lane);
                end
                byte_idx++;
                in_packet = !lane.last;
            end else if (in_packet) begin
                abort_run("lane valid dropped in the middle of a packet");
            end
            after_last = lane.valid && lane.last;
        end
    end

    initial begin : stimulus
        int wait_cnt;
        pixel           = '0;
        tx_byte_reset_n = 1'b0;
        rng_state       = 32'd43;
        repeat (3) @(posedge tx_byte_clock);
        tx_byte_reset_n <= 1'b1;

        for (int i = 0; i < 50; i++) begin
            @(negedge tx_byte_clock);
            if (lane.valid !== 1'b0) begin
                abort_run($sformatf("[FAIL] idle_after_reset: expected valid=0, actual valid=%0b",
                                    lane.valid));
            end
        end

        for (int f = 0; f < 3; f++) begin
            drive_frame(1 + rand_below(4));
        end

        wait_cnt = 0;
        while ((exp_bytes.size() != 0 || in_packet) && wait_cnt < DRAIN_LIMIT) begin
            @(posedge tx_byte_clock);
            wait_cnt++;
        end
        if (wait_cnt >= DRAIN_LIMIT) begin
            abort_run("timed out waiting for the expected packets on the lane");
        end else begin
            repeat (4) @(posedge tx_byte_clock);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: compile.f
csi2_tx_pkg.sv
raw10_packer.sv
csi2_line_fifo.sv
csi2_header_ecc.sv
csi2_payload_crc.sv
csi2_packet_ctrl.sv
csi2_tx_top.sv
csi2_tx_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= csi2_tx_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test: pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
